// ==== hdl/downscale_pkg.sv ====
package downscale_pkg;

    // pixel format
    localparam int CH_W = 8;

    // averaging window, square and power of two
    localparam int BLK        = 4;
    localparam int BLK_LOG2   = 2;
    localparam int BLK_PIXELS = BLK * BLK;

    typedef logic [CH_W-1:0] chan_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } pixel_t;

    // index 0 is the top left pixel, row-major inside the block
    typedef pixel_t [BLK_PIXELS-1:0] block_t;

endpackage

// ==== hdl/block_addr_gen.sv ====
`timescale 1ns/1ps

module block_addr_gen import downscale_pkg::*; #(
    parameter int IMG_W     = 640,
    parameter int IMG_H     = 480,
    parameter int IN_ADDR_W = 20
)(
    input  logic                 iclk,
    input  logic                 i_reset,
    input  logic                 i_start,
    input  logic [IN_ADDR_W-1:0] i_start_ptr,
    input  logic                 i_frame_done,
    output logic                 o_rd_en,
    output logic [IN_ADDR_W-1:0] o_rd_addr,
    output logic                 o_busy,
    output logic                 o_frame_last
);

    localparam int BLK_X = IMG_W / BLK;
    localparam int BLK_Y = IMG_H / BLK;
    localparam int BX_W  = (BLK_X > 1) ? $clog2(BLK_X) : 1;
    localparam int BY_W  = (BLK_Y > 1) ? $clog2(BLK_Y) : 1;

    logic                 rd_active;
    logic [IN_ADDR_W-1:0] base_ptr;
    logic [BLK_LOG2-1:0]  col;       // offset inside the block
    logic [BLK_LOG2-1:0]  row;
    logic [BX_W-1:0]      bx;        // block coordinates
    logic [BY_W-1:0]      by;

    logic col_last;
    logic row_last;
    logic bx_last;
    logic by_last;
    logic start_ok;

    logic [BY_W+BLK_LOG2-1:0] pix_y;
    logic [BX_W+BLK_LOG2-1:0] pix_x;

    assign col_last = (col == BLK_LOG2'(BLK - 1));
    assign row_last = (row == BLK_LOG2'(BLK - 1));
    assign bx_last  = (bx == BX_W'(BLK_X - 1));
    assign by_last  = (by == BY_W'(BLK_Y - 1));
    assign start_ok = i_start & ~o_busy;   // start ignored while busy

    assign o_frame_last = rd_active & col_last & row_last & bx_last & by_last;

    // block size is a power of two so the pixel coordinate is a concatenation
    assign pix_y = {by, row};
    assign pix_x = {bx, col};

    assign o_rd_addr = base_ptr + IN_ADDR_W'(pix_y * IMG_W) + IN_ADDR_W'(pix_x);
    assign o_rd_en   = rd_active;

    always_ff @(posedge iclk) begin
        if (i_reset) begin
            o_busy    <= 1'b0;
            rd_active <= 1'b0;
            col       <= '0;
            row       <= '0;
            bx        <= '0;
            by        <= '0;
        end else if (start_ok) begin
            o_busy    <= 1'b1;
            rd_active <= 1'b1;
            col       <= '0;
            row       <= '0;
            bx        <= '0;
            by        <= '0;
        end else begin
            if (i_frame_done)
                o_busy <= 1'b0;
            if (rd_active) begin
                col <= col + 1'b1;   // wraps at block edge
                if (col_last) begin
                    row <= row + 1'b1;
                    if (row_last) begin
                        // next block to the right, or first block of next block row
                        bx <= bx_last ? '0 : bx + 1'b1;
                        if (bx_last)
                            by <= by_last ? '0 : by + 1'b1;
                    end
                end
                if (o_frame_last)
                    rd_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge iclk) begin
        if (start_ok)
            base_ptr <= i_start_ptr;
    end

endmodule

// ==== hdl/block_gather.sv ====
`timescale 1ns/1ps

module block_gather import downscale_pkg::*; #(
    parameter int OUT_ADDR_W = 13
)(
    input  logic                  iclk,
    input  logic                  i_reset,
    input  logic                  i_start,
    input  logic                  i_rd_en,
    input  pixel_t                i_rd_data,
    output logic                  o_blk_valid,
    output block_t                o_blk,
    output logic [OUT_ADDR_W-1:0] o_blk_addr
);

    localparam int CNT_W = $clog2(BLK_PIXELS);

    logic             rd_en_d;   // strobe aligned with returning data
    logic [CNT_W-1:0] pix_cnt;
    logic             pix_last;

    assign pix_last = (pix_cnt == CNT_W'(BLK_PIXELS - 1));

    always_ff @(posedge iclk) begin
        if (i_reset) begin
            rd_en_d     <= 1'b0;
            pix_cnt     <= '0;
            o_blk_valid <= 1'b0;
        end else begin
            rd_en_d     <= i_rd_en;
            o_blk_valid <= rd_en_d & pix_last;
            if (i_start)
                pix_cnt <= '0;
            else if (rd_en_d)
                pix_cnt <= pix_cnt + 1'b1;
        end
    end

    // running output address, one step per finished block
    always_ff @(posedge iclk) begin
        if (i_reset)
            o_blk_addr <= '0;
        else if (i_start)
            o_blk_addr <= '0;
        else if (o_blk_valid)
            o_blk_addr <= o_blk_addr + 1'b1;
    end

    // newest pixel enters at the top, first pixel ends up at index 0
    always_ff @(posedge iclk) begin
        if (rd_en_d)
            o_blk <= {i_rd_data, o_blk[BLK_PIXELS-1:1]};
    end

endmodule

// ==== hdl/mean_tree.sv ====
`timescale 1ns/1ps

module mean_tree import downscale_pkg::*; #(
    parameter int OUT_ADDR_W = 13
)(
    input  logic                  iclk,
    input  logic                  i_reset,
    input  logic                  i_valid,
    input  block_t                i_blk,
    input  logic [OUT_ADDR_W-1:0] i_addr,
    output logic                  o_valid,
    output pixel_t                o_mean,
    output logic [OUT_ADDR_W-1:0] o_addr
);

    localparam int ROW_W = CH_W + BLK_LOG2;       // sum of one row
    localparam int TOT_W = CH_W + 2 * BLK_LOG2;   // sum of whole block

    typedef struct packed {
        logic [ROW_W-1:0] r;
        logic [ROW_W-1:0] g;
        logic [ROW_W-1:0] b;
    } row_sum_t;

    row_sum_t [BLK-1:0]    s1_sum;
    logic                  s1_valid;
    logic [OUT_ADDR_W-1:0] s1_addr;

    logic [TOT_W-1:0] tot_r;
    logic [TOT_W-1:0] tot_g;
    logic [TOT_W-1:0] tot_b;

    function automatic row_sum_t row_sum(input pixel_t [BLK-1:0] px);
        row_sum_t s;
        s = '0;
        for (int j = 0; j < BLK; j++) begin
            s.r = s.r + ROW_W'(px[j].r);
            s.g = s.g + ROW_W'(px[j].g);
            s.b = s.b + ROW_W'(px[j].b);
        end
        return s;
    endfunction

    // stage one, per-row sums
    always_ff @(posedge iclk) begin
        for (int i = 0; i < BLK; i++)
            s1_sum[i] <= row_sum(i_blk[i*BLK +: BLK]);
        s1_addr <= i_addr;
    end

    always_comb begin
        tot_r = '0;
        tot_g = '0;
        tot_b = '0;
        for (int i = 0; i < BLK; i++) begin
            tot_r = tot_r + TOT_W'(s1_sum[i].r);
            tot_g = tot_g + TOT_W'(s1_sum[i].g);
            tot_b = tot_b + TOT_W'(s1_sum[i].b);
        end
    end

    // stage two, divide by 16 by dropping the low bits
    always_ff @(posedge iclk) begin
        o_mean.r <= tot_r[TOT_W-1 -: CH_W];
        o_mean.g <= tot_g[TOT_W-1 -: CH_W];
        o_mean.b <= tot_b[TOT_W-1 -: CH_W];
        o_addr   <= s1_addr;
    end

    always_ff @(posedge iclk) begin
        if (i_reset) begin
            s1_valid <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            s1_valid <= i_valid;
            o_valid  <= s1_valid;
        end
    end

endmodule

// ==== hdl/im_downscale_top.sv ====
`timescale 1ns/1ps

module im_downscale_top import downscale_pkg::*; #(
    parameter int IMG_W      = 640,
    parameter int IMG_H      = 480,
    parameter int IN_ADDR_W  = $clog2(IMG_W * IMG_H) + 1,   // room for a start offset
    parameter int OUT_ADDR_W = $clog2((IMG_W / BLK) * (IMG_H / BLK))
)(
    input  logic                  iclk,
    input  logic                  i_reset,
    input  logic                  i_start,
    input  logic [IN_ADDR_W-1:0]  i_start_ptr,
    output logic                  o_rd_en,
    output logic [IN_ADDR_W-1:0]  o_rd_addr,
    input  pixel_t                i_rd_data,
    output logic                  o_wr_en,
    output logic [OUT_ADDR_W-1:0] o_wr_addr,
    output pixel_t                o_wr_data,
    output logic                  o_busy,
    output logic                  o_done
);

    localparam int OUT_PIXELS = (IMG_W / BLK) * (IMG_H / BLK);

    logic                  start_acc;
    logic                  frame_last;
    logic                  frame_done;
    logic                  reads_done;   // all reads of the frame issued
    logic [OUT_ADDR_W-1:0] wr_cnt;

    logic                  blk_valid;
    block_t                blk;
    logic [OUT_ADDR_W-1:0] blk_addr;

    assign start_acc  = i_start & ~o_busy;
    assign frame_done = o_wr_en & reads_done & (wr_cnt == OUT_ADDR_W'(OUT_PIXELS - 1));

    block_addr_gen #(
        .IMG_W     (IMG_W),
        .IMG_H     (IMG_H),
        .IN_ADDR_W (IN_ADDR_W)
    ) block_addr_gen_i (
        .iclk         (iclk),
        .i_reset      (i_reset),
        .i_start      (i_start),
        .i_start_ptr  (i_start_ptr),
        .i_frame_done (frame_done),
        .o_rd_en      (o_rd_en),
        .o_rd_addr    (o_rd_addr),
        .o_busy       (o_busy),
        .o_frame_last (frame_last)
    );

    block_gather #(
        .OUT_ADDR_W (OUT_ADDR_W)
    ) block_gather_i (
        .iclk        (iclk),
        .i_reset     (i_reset),
        .i_start     (start_acc),
        .i_rd_en     (o_rd_en),
        .i_rd_data   (i_rd_data),
        .o_blk_valid (blk_valid),
        .o_blk       (blk),
        .o_blk_addr  (blk_addr)
    );

    // write port comes straight off the tree
    mean_tree #(
        .OUT_ADDR_W (OUT_ADDR_W)
    ) mean_tree_i (
        .iclk    (iclk),
        .i_reset (i_reset),
        .i_valid (blk_valid),
        .i_blk   (blk),
        .i_addr  (blk_addr),
        .o_valid (o_wr_en),
        .o_mean  (o_wr_data),
        .o_addr  (o_wr_addr)
    );

    always_ff @(posedge iclk) begin
        if (i_reset) begin
            wr_cnt     <= '0;
            reads_done <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_done <= frame_done;   // one cycle after the last write
            if (start_acc) begin
                wr_cnt     <= '0;
                reads_done <= 1'b0;
            end else begin
                if (frame_last)
                    reads_done <= 1'b1;
                if (o_wr_en)
                    wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== bench/downscale_checker.sv ====
`timescale 1ns/1ps

module downscale_checker import downscale_pkg::*; #(
    parameter int IMG_W      = 16,
    parameter int IMG_H      = 8,
    parameter int MEM_DEPTH  = 256,
    parameter int OUT_ADDR_W = 3
)(
    input  logic                  iclk,
    input  logic                  i_reset,
    input  logic                  i_rd_en,
    input  logic                  i_wr_en,
    input  logic [OUT_ADDR_W-1:0] i_wr_addr,
    input  pixel_t                i_wr_data,
    input  logic                  i_busy,
    input  logic                  i_done,
    input  pixel_t                i_mem [MEM_DEPTH]
);

    localparam int BLK_X  = IMG_W / BLK;
    localparam int BLK_Y  = IMG_H / BLK;
    localparam int N_OUT  = BLK_X * BLK_Y;
    localparam int MEM_AW = $clog2(MEM_DEPTH);
    localparam int OUT_IW = $clog2(N_OUT);

    pixel_t exp_pix [N_OUT];
    string  cur_name = "none";
    bit     active = 1'b0;
    int     cur_exp_writes = 0;

    // running totals from the monitor
    int wr_total = 0;
    int done_total = 0;
    int mon_errs = 0;

    int snap_writes = 0;   // totals at test start
    int snap_dones = 0;
    int snap_errs = 0;

    int task_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always @(posedge iclk) begin
        int idx;
        if (!i_reset) begin
            if (i_wr_en) begin
                idx = wr_total - snap_writes;
                wr_total = wr_total + 1;
                if (!active) begin
                    $display("ERROR: write to address %0d with no test running", i_wr_addr);
                    mon_errs = mon_errs + 1;
                end else if (idx >= N_OUT) begin
                    $display("ERROR: %s made an extra write to address %0d", cur_name, i_wr_addr);
                    mon_errs = mon_errs + 1;
                end else begin
                    if (int'(i_wr_addr) != idx) begin
                        $display("ERROR: %s wrote output pixel %0d to address %0d",
                                 cur_name, idx, i_wr_addr);
                        mon_errs = mon_errs + 1;
                    end
                    if (i_wr_data !== exp_pix[OUT_IW'(idx)]) begin
                        $display("MISMATCH %s pixel %0d expected %06h actual %06h",
                                 cur_name, idx, exp_pix[OUT_IW'(idx)], i_wr_data);
                        mon_errs = mon_errs + 1;
                    end
                end
            end
            if (i_done) begin
                done_total = done_total + 1;
                if (!active) begin
                    $display("ERROR: done pulse with no test running");
                    mon_errs = mon_errs + 1;
                end else if (wr_total - snap_writes != cur_exp_writes) begin
                    $display("ERROR: %s raised done after %0d writes instead of %0d",
                             cur_name, wr_total - snap_writes, cur_exp_writes);
                    mon_errs = mon_errs + 1;
                end
                if (i_busy) begin
                    $display("ERROR: %s still shows busy in the done cycle", cur_name);
                    mon_errs = mon_errs + 1;
                end
            end
        end
    end

    task automatic check_idle();
        if (i_busy || i_done || i_rd_en || i_wr_en) begin
            $display("ERROR: busy, done, read or write strobe is high after reset");
            task_errs = task_errs + 1;
        end
    endtask

    // block means straight from the memory image
    task automatic begin_test(input string name, input int ptr, input int exp_writes);
        int sum_r;
        int sum_g;
        int sum_b;
        int a;
        int n;
        cur_name       = name;
        cur_exp_writes = exp_writes;
        for (int by = 0; by < BLK_Y; by++) begin
            for (int bx = 0; bx < BLK_X; bx++) begin
                sum_r = 0;
                sum_g = 0;
                sum_b = 0;
                for (int r = 0; r < BLK; r++) begin
                    for (int c = 0; c < BLK; c++) begin
                        a = (ptr + (BLK * by + r) * IMG_W + BLK * bx + c) % MEM_DEPTH;
                        sum_r = sum_r + int'(i_mem[MEM_AW'(a)].r);
                        sum_g = sum_g + int'(i_mem[MEM_AW'(a)].g);
                        sum_b = sum_b + int'(i_mem[MEM_AW'(a)].b);
                    end
                end
                n = by * BLK_X + bx;
                exp_pix[OUT_IW'(n)].r = 8'(sum_r / BLK_PIXELS);   // truncated
                exp_pix[OUT_IW'(n)].g = 8'(sum_g / BLK_PIXELS);
                exp_pix[OUT_IW'(n)].b = 8'(sum_b / BLK_PIXELS);
            end
        end
        snap_writes = wr_total;
        snap_dones  = done_total;
        snap_errs   = mon_errs;
        active      = 1'b1;
    endtask

    task automatic end_test();
        int n_wr;
        int n_done;
        int errs;
        n_wr   = wr_total - snap_writes;
        n_done = done_total - snap_dones;
        errs   = 0;
        if (n_wr != cur_exp_writes) begin
            $display("ERROR: %s made %0d writes, expected %0d", cur_name, n_wr, cur_exp_writes);
            errs = errs + 1;
        end
        if (n_done == 0) begin
            $display("ERROR: %s never raised done", cur_name);
            errs = errs + 1;
        end else if (n_done > 1) begin
            $display("ERROR: %s raised done %0d times", cur_name, n_done);
            errs = errs + 1;
        end
        if (i_busy) begin
            $display("ERROR: %s left busy high after the frame", cur_name);
            errs = errs + 1;
        end
        task_errs = task_errs + errs;
        errs      = errs + mon_errs - snap_errs;
        active    = 1'b0;
        tests_run = tests_run + 1;
        if (errs == 0) begin
            $display("test %0d %s ok, %0d writes", tests_run, cur_name, n_wr);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s failed with %0d errors", tests_run, cur_name, errs);
        end
    endtask

    function automatic int error_count();
        return mon_errs + task_errs;
    endfunction

    function automatic int run_count();
        return tests_run;
    endfunction

    function automatic int failed_count();
        return tests_failed;
    endfunction

endmodule

// ==== bench/tb_im_downscale.sv ====
`timescale 1ns/1ps

module tb_im_downscale import downscale_pkg::*; ();

    localparam int IMG_W           = 16;
    localparam int IMG_H           = 8;
    localparam int IN_ADDR_W       = 8;
    localparam int OUT_ADDR_W      = 4;   // spare bit exposes an address count that runs past 7
    localparam int MEM_DEPTH       = 1 << IN_ADDR_W;
    localparam int FRAME_READS     = IMG_W * IMG_H;
    localparam int N_TESTS         = 6;
    localparam int TI_W            = $clog2(N_TESTS);
    localparam int DONE_WAIT       = FRAME_READS + 20;
    localparam int RESTART_DELAY   = 5;
    localparam int WATCHDOG_CYCLES = N_TESTS * (FRAME_READS + 40);

    typedef enum logic [1:0] {
        FILL_CONST,
        FILL_RANDOM,
        FILL_RAMP,
        FILL_ONES
    } fill_e;

    typedef struct packed {
        logic [IN_ADDR_W-1:0] ptr;
        fill_e                kind;
        logic                 restart;      // second start while busy
        pixel_t               value;        // constant fill only
        logic [3:0]           exp_writes;
    } test_row_t;

    logic                  iclk;
    logic                  reset;
    logic                  start;
    logic [IN_ADDR_W-1:0]  start_ptr;
    logic                  rd_en;
    logic [IN_ADDR_W-1:0]  rd_addr;
    pixel_t                rd_data = '0;
    logic                  wr_en;
    logic [OUT_ADDR_W-1:0] wr_addr;
    pixel_t                wr_data;
    logic                  busy;
    logic                  done;

    pixel_t      mem [MEM_DEPTH];
    test_row_t   tests [N_TESTS];
    string       test_name [N_TESTS];
    logic [31:0] rng_state = 32'd34905;

    im_downscale_top #(
        .IMG_W      (IMG_W),
        .IMG_H      (IMG_H),
        .IN_ADDR_W  (IN_ADDR_W),
        .OUT_ADDR_W (OUT_ADDR_W)
    ) im_downscale_top_i (
        .iclk        (iclk),
        .i_reset     (reset),
        .i_start     (start),
        .i_start_ptr (start_ptr),
        .o_rd_en     (rd_en),
        .o_rd_addr   (rd_addr),
        .i_rd_data   (rd_data),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data),
        .o_busy      (busy),
        .o_done      (done)
    );

    downscale_checker #(
        .IMG_W      (IMG_W),
        .IMG_H      (IMG_H),
        .MEM_DEPTH  (MEM_DEPTH),
        .OUT_ADDR_W (OUT_ADDR_W)
    ) downscale_checker_i (
        .iclk      (iclk),
        .i_reset   (reset),
        .i_rd_en   (rd_en),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_busy    (busy),
        .i_done    (done),
        .i_mem     (mem)
    );

    initial begin
        iclk = 1'b0;
        forever #10 iclk = ~iclk;
    end

    always @(posedge iclk) begin
        if (rd_en)
            rd_data <= mem[rd_addr];   // one cycle latency
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_test_table();
        tests[0] = '{8'd0,   FILL_CONST,  1'b0, 24'h5A3C96, 4'd8};
        tests[1] = '{8'd0,   FILL_RANDOM, 1'b0, 24'h000000, 4'd8};
        tests[2] = '{8'd37,  FILL_RAMP,   1'b0, 24'h000000, 4'd8};
        tests[3] = '{8'd0,   FILL_ONES,   1'b0, 24'h000000, 4'd8};
        tests[4] = '{8'd5,   FILL_RANDOM, 1'b1, 24'h000000, 4'd8};
        tests[5] = '{8'd100, FILL_RANDOM, 1'b0, 24'h000000, 4'd8};
        test_name[0] = "const_base0";
        test_name[1] = "random_base0";
        test_name[2] = "ramp_offset";
        test_name[3] = "all_ones";
        test_name[4] = "start_while_busy";
        test_name[5] = "random_offset";
    endtask

    task automatic fill_memory(input test_row_t row);
        for (int a = 0; a < MEM_DEPTH; a++) begin
            case (row.kind)
                FILL_CONST:  mem[IN_ADDR_W'(a)] = row.value;
                FILL_RANDOM: begin
                    rng_state = xorshift32(rng_state);
                    mem[IN_ADDR_W'(a)] = pixel_t'(rng_state[23:0]);
                end
                FILL_RAMP: begin
                    mem[IN_ADDR_W'(a)].r = 8'(a);
                    mem[IN_ADDR_W'(a)].g = 8'(a * 3 + 7);
                    mem[IN_ADDR_W'(a)].b = 8'(255 - a);
                end
                default:     mem[IN_ADDR_W'(a)] = 24'hFFFFFF;
            endcase
        end
    endtask

    task automatic pulse_start(input logic [IN_ADDR_W-1:0] ptr);
        @(posedge iclk);
        start     <= 1'b1;
        start_ptr <= ptr;
        @(posedge iclk);
        start     <= 1'b0;
    endtask

    initial begin
        int        cycles;
        test_row_t row;
        string     name;
        reset     = 1'b1;
        start     = 1'b0;
        start_ptr = '0;
        load_test_table();
        repeat (16) @(posedge iclk);
        reset <= 1'b0;
        @(posedge iclk);
        downscale_checker_i.check_idle();

        for (int i = 0; i < N_TESTS; i++) begin
            row  = tests[TI_W'(i)];
            name = test_name[TI_W'(i)];
            fill_memory(row);
            @(posedge iclk);
            downscale_checker_i.begin_test(name, int'(row.ptr), int'(row.exp_writes));
            pulse_start(row.ptr);
            if (row.restart) begin
                repeat (RESTART_DELAY) @(posedge iclk);
                pulse_start(row.ptr + IN_ADDR_W'(16));   // must be ignored
            end
            cycles = 0;
            while (!done && cycles < DONE_WAIT) begin
                @(posedge iclk);
                cycles = cycles + 1;
            end
            repeat (4) @(posedge iclk);   // catch stray writes or done pulses
            downscale_checker_i.end_test();
        end

        $display("%0d tests run, %0d failed, %0d errors", downscale_checker_i.run_count(),
                 downscale_checker_i.failed_count(), downscale_checker_i.error_count());
        if (downscale_checker_i.error_count() == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge iclk);
        $display("ERROR: run exceeded %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/downscale_pkg.sv
hdl/block_addr_gen.sv
hdl/block_gather.sv
hdl/mean_tree.sv
hdl/im_downscale_top.sv
bench/downscale_checker.sv
bench/tb_im_downscale.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = tb_im_downscale
RTL_TOP   = im_downscale_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
